// File: ixop_patterns.txt
# Commands: W addr data, R addr expect, O opcode is_y, C field expect.
# Numbers are hex; C fields are ix, iy, sp, pc or cb.
C sp 00F0
C ix 0000
W 0010 5A
W 0023 C3
W 0047 96
W 007E 1F
W 00F0 34
W 00F1 12
O E1 0
C ix 1234
C sp 00F2
W 00F2 CD
W 00F3 AB
O E1 1
C iy ABCD
C ix 1234
W 00F3 00
W 00F2 00
O E5 1
C sp 00F2
R 00F3 AB
R 00F2 CD
W 00F2 78
W 00F3 56
O E3 0
C ix 5678
C sp 00F2
R 00F2 34
R 00F3 12
O E9 0
C pc 5678
O F9 1
C sp ABCD
O CB 0
C cb 1
O 3A 0
C cb 0
C ix 5678
C iy ABCD
C sp ABCD
C pc 5678
R 0023 C3

// File: vlog.f
+incdir+.
ixop_pkg.sv
ixop_decoder.sv
ixop_sequencer.sv
ixop_regs.sv
mem_arbiter.sv
stack_ram.sv
ixop_top.sv
tb_clkgen.sv
tb_ixop.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ixop -f vlog.f

out=$(./obj_dir/Vtb_ixop) || true
printf '%s\n' "$out"

# The run passes only if the pass line was printed.
printf '%s\n' "$out" | grep -qx "TEST PASS"

// File: tb_ixop.sv
// Index op unit testbench
`timescale 1ns/1ps

module tb_ixop import ixop_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        op_strobe;
    data_t       op_byte;
    logic        is_y;
    logic        op_done;
    logic        busy;
    logic        cb_prefix;
    logic        host_strobe;
    logic        host_we;
    addr_t       host_addr;
    data_t       host_wdata;
    data_t       host_rdata;
    logic        host_rvalid;
    regs_t       regs;

    logic [7:0]  cmd_q[$];
    logic [31:0] arg_a_q[$];
    logic [31:0] arg_b_q[$];
    addr_t       low_addrs[$];   // Host-written bytes below the stack area.
    data_t       shadow [256];
    int          errors;
    int          checks;
    logic        loaded;
    logic        op_finished;

    tb_clkgen #(.PERIOD_NS(20)) i_tb_clkgen (.clk(clk));

    ixop_top i_ixop_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_strobe   (op_strobe),
        .op_byte     (op_byte),
        .is_y        (is_y),
        .op_done     (op_done),
        .busy        (busy),
        .cb_prefix   (cb_prefix),
        .host_strobe (host_strobe),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .regs        (regs)
    );

    // ****************************************
    // Pattern file
    // ****************************************
    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  cmd;
        logic [15:0] field_name;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("ixop_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open ixop_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3 || line[0] == "#") continue;  // Blank or comment.
            a = '0;
            b = '0;
            field_name = '0;
            if (line[0] == "C") begin
                n = $sscanf(line, "%c %s %h", cmd, field_name, b);
                a = {16'd0, field_name};
            end else begin
                n = $sscanf(line, "%c %h %h", cmd, a, b);
            end
            if (n != 3) begin
                $display("Pattern line could not be parsed: %s", line);
                errors++;
            end else begin
                cmd_q.push_back(cmd);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    // ****************************************
    // Host port and op tasks
    // ****************************************
    task automatic host_write(input addr_t addr, input data_t data);
        @(negedge clk);
        host_strobe = 1'b1;
        host_we     = 1'b1;
        host_addr   = addr;
        host_wdata  = data;
        @(negedge clk);
        host_strobe = 1'b0;
        host_we     = 1'b0;
        shadow[addr[7:0]] = data;
        if (addr < 16'h0080) low_addrs.push_back(addr);
    endtask

    // Called on a falling edge; the data shows up one cycle later.
    task automatic host_read(input addr_t addr, input data_t expected);
        host_strobe = 1'b1;
        host_we     = 1'b0;
        host_addr   = addr;
        @(negedge clk);
        host_strobe = 1'b0;
        #5;
        checks++;
        if (host_rvalid !== 1'b1) begin
            $display("FAILED host_rvalid: expected 1, got %h", host_rvalid);
            errors++;
        end else if (host_rdata !== expected) begin
            $display("FAILED host_rdata at %h: expected %h, got %h", addr, expected, host_rdata);
            errors++;
        end
    endtask

    task automatic run_op(input data_t opcode, input logic y);
        addr_t pick;
        @(negedge clk);
        op_strobe   = 1'b1;
        op_byte     = opcode;
        is_y        = y;
        op_finished = 1'b0;
        fork
            begin
                @(negedge clk);
                op_strobe = 1'b0;
                #5;
                while (op_done !== 1'b1) begin
                    @(negedge clk);
                    #5;
                end
                op_finished = 1'b1;
            end
            begin
                // Host reads compete with the engine for the RAM.
                while (!op_finished) begin
                    @(negedge clk);
                    if (!op_finished && low_addrs.size() > 0 && $urandom_range(2, 0) == 0) begin
                        pick = low_addrs[$urandom_range(low_addrs.size() - 1, 0)];
                        host_read(pick, shadow[pick[7:0]]);
                    end
                end
            end
        join
    endtask

    task automatic check_field(input logic [15:0] field, input logic [31:0] expected);
        logic [15:0] actual;
        string       name;
        @(negedge clk);
        #5;
        case (field)
            "ix": begin
                actual = regs.ix;
                name   = "regs.ix";
            end
            "iy": begin
                actual = regs.iy;
                name   = "regs.iy";
            end
            "sp": begin
                actual = regs.sp;
                name   = "regs.sp";
            end
            "pc": begin
                actual = regs.pc;
                name   = "regs.pc";
            end
            "cb": begin
                actual = {15'd0, cb_prefix};
                name   = "cb_prefix";
            end
            default: begin
                $display("Pattern names an unknown register field %s", field);
                errors++;
                return;
            end
        endcase
        checks++;
        if (actual !== expected[15:0]) begin
            $display("FAILED %s: expected %h, got %h", name, expected[15:0], actual);
            errors++;
        end
    endtask

    // ****************************************
    // Main sequence
    // ****************************************
    initial begin
        rst_n       = 1'b0;
        op_strobe   = 1'b0;
        op_byte     = '0;
        is_y        = 1'b0;
        host_strobe = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        errors      = 0;
        checks      = 0;
        loaded      = 1'b0;
        op_finished = 1'b0;
        void'($urandom(46));
        load_patterns();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #5;
        checks++;
        if ({op_done, busy, host_rvalid, cb_prefix} !== 4'b0000) begin
            $display("FAILED {op_done,busy,host_rvalid,cb_prefix} after reset: expected 0, got %h",
                     {op_done, busy, host_rvalid, cb_prefix});
            errors++;
        end
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "W": host_write(arg_a_q[i][15:0], arg_b_q[i][7:0]);
                "R": begin
                    @(negedge clk);
                    host_read(arg_a_q[i][15:0], arg_b_q[i][7:0]);
                end
                "O": run_op(arg_a_q[i][7:0], arg_b_q[i][0]);
                "C": check_field(arg_a_q[i][15:0], arg_b_q[i]);
                default: begin
                    $display("Pattern command %c is not known", cmd_q[i]);
                    errors++;
                end
            endcase
        end
        repeat (2) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // The watchdog limit grows with the number of pattern lines.
    initial begin
        int limit;
        wait (loaded);
        limit = (cmd_q.size() + 1) * 60 + 16;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: tb_clkgen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: ixop_top.sv
// Index op unit top
`timescale 1ns/1ps

module ixop_top import ixop_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  op_strobe,
    input  data_t op_byte,
    input  logic  is_y,
    output logic  op_done,
    output logic  busy,
    output logic  cb_prefix,
    input  logic  host_strobe,
    input  logic  host_we,
    input  addr_t host_addr,
    input  data_t host_wdata,
    output data_t host_rdata,
    output logic  host_rvalid,
    output regs_t regs
);

    ctrl_t    ctrl;
    data_t    opcode;
    logic     op_is_y;
    step_t    step;
    logic     apply;
    logic     wb;
    logic     eng_gnt;
    mem_req_t eng_req;
    mem_req_t ram_req;

    // ****************************************
    // Control
    // ****************************************
    ixop_decoder i_ixop_decoder (
        .opcode (opcode),
        .is_y   (op_is_y),
        .step   (step),
        .ctrl   (ctrl),
        .known  ()
    );

    ixop_sequencer i_ixop_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_strobe (op_strobe),
        .op_byte   (op_byte),
        .is_y_in   (is_y),
        .ctrl      (ctrl),
        .eng_gnt   (eng_gnt),
        .opcode    (opcode),
        .is_y      (op_is_y),
        .step      (step),
        .apply     (apply),
        .wb        (wb),
        .op_done   (op_done),
        .busy      (busy)
    );

    // ****************************************
    // Datapath and memory
    // ****************************************
    ixop_regs i_ixop_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .is_y      (op_is_y),
        .apply     (apply),
        .wb        (wb),
        .rdata     (host_rdata),
        .eng_req   (eng_req),
        .regs      (regs),
        .cb_prefix (cb_prefix),
        .op_strobe (op_strobe)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_strobe (host_strobe),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .eng_req     (eng_req),
        .eng_gnt     (eng_gnt),
        .ram_req     (ram_req),
        .host_rvalid (host_rvalid)
    );

    stack_ram i_stack_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (host_rdata)  // Shared by the host and the engine.
    );

endmodule

// File: stack_ram.sv
// Stack byte RAM
`timescale 1ns/1ps
`include "ixop_cfg.svh"

module stack_ram import ixop_pkg::*; (
    input  logic     clk,
    input  mem_req_t ram_req,
    output data_t    rdata
);

    localparam int AW = $clog2(`IXOP_RAM_DEPTH);

    data_t         mem [`IXOP_RAM_DEPTH];
    logic [AW-1:0] index;

    assign index = ram_req.addr[AW-1:0];  // Upper address bits wrap.

    always_ff @(posedge clk) begin
        if (ram_req.req) begin
            if (ram_req.we) mem[index] <= ram_req.wdata;
            else rdata <= mem[index];
        end
    end

endmodule

// File: mem_arbiter.sv
// Stack RAM arbiter
`timescale 1ns/1ps

module mem_arbiter import ixop_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     host_strobe,
    input  logic     host_we,
    input  addr_t    host_addr,
    input  data_t    host_wdata,
    input  mem_req_t eng_req,
    output logic     eng_gnt,
    output mem_req_t ram_req,
    output logic     host_rvalid
);

    // The host cannot stall, so it always owns the port when it strobes.
    always_comb begin
        if (host_strobe) begin
            ram_req.req   = 1'b1;
            ram_req.we    = host_we;
            ram_req.addr  = host_addr;
            ram_req.wdata = host_wdata;
        end else begin
            ram_req = eng_req;
        end
    end

    assign eng_gnt = eng_req.req && !host_strobe;

    always_ff @(posedge clk) begin
        if (!rst_n) host_rvalid <= 1'b0;
        else host_rvalid <= host_strobe && !host_we;  // RAM data is one cycle behind.
    end

    // A blocked engine keeps its request up until it gets through.
    assert property (@(posedge clk) disable iff (!rst_n)
                     eng_req.req && host_strobe |-> !eng_gnt ##1 eng_req.req)
        else $error("engine request dropped while the host held the RAM");

endmodule

// File: ixop_regs.sv
// Index register datapath
`timescale 1ns/1ps
`include "ixop_cfg.svh"

module ixop_regs import ixop_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ctrl_t    ctrl,
    input  logic     is_y,
    input  logic     apply,
    input  logic     wb,
    input  data_t    rdata,
    output mem_req_t eng_req,
    output regs_t    regs,
    output logic     cb_prefix,
    input  logic     op_strobe
);

    addr_t ix;
    addr_t iy;
    addr_t sp;
    addr_t pc;
    addr_t idx;
    addr_t idx_next;
    data_t dt;
    data_t dtex;
    logic  upd;

    assign idx = is_y ? iy : ix;
    assign upd = apply || wb;

    // ****************************************
    // Engine memory request
    // ****************************************
    always_comb begin
        eng_req.req   = ctrl.mem_op && !wb;
        eng_req.we    = ctrl.mem_we;
        eng_req.addr  = ctrl.addr_plus1 ? sp + addr_t'(1) : sp;
        eng_req.wdata = ctrl.wdata_hi ? idx[15:8] : idx[7:0];
    end

    always_comb begin
        idx_next = idx;
        if (ctrl.idx_from_dt) idx_next = {dtex, dt};
        if (wb && ctrl.wb_sel == WB_IDX_LO) idx_next[7:0] = rdata;  // Little endian.
        if (wb && ctrl.wb_sel == WB_IDX_HI) idx_next[15:8] = rdata;
    end

    // ****************************************
    // Register updates
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ix        <= `IXOP_IX_RESET;
            iy        <= `IXOP_IY_RESET;
            sp        <= `IXOP_SP_RESET;
            pc        <= '0;
            cb_prefix <= 1'b0;
        end else begin
            if (upd) begin
                if (is_y) iy <= idx_next;
                else ix <= idx_next;
                if (ctrl.inc_sp) sp <= sp + addr_t'(1);
                else if (ctrl.dec_sp) sp <= sp - addr_t'(1);
                else if (ctrl.write_sp) sp <= idx;
                if (ctrl.write_pc) pc <= idx;
            end
            if (op_strobe) cb_prefix <= 1'b0;
            else if (apply && ctrl.set_cb) cb_prefix <= 1'b1;
        end
    end

    // Exchange temporaries for EX (SP).
    always_ff @(posedge clk) begin
        if (wb && ctrl.wb_sel == WB_DT) dt <= rdata;
        if (wb && ctrl.wb_sel == WB_DTEX) dtex <= rdata;
    end

    assign regs = '{ix: ix, iy: iy, sp: sp, pc: pc};

endmodule

// File: ixop_sequencer.sv
// Index op step sequencer
`timescale 1ns/1ps

module ixop_sequencer import ixop_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  op_strobe,
    input  data_t op_byte,
    input  logic  is_y_in,
    input  ctrl_t ctrl,
    input  logic  eng_gnt,
    output data_t opcode,
    output logic  is_y,
    output step_t step,
    output logic  apply,
    output logic  wb,
    output logic  op_done,
    output logic  busy
);

    seq_state_e state;
    logic       step_end;

    // A write or a step without memory ends in the access cycle itself.
    assign apply    = (state == SEQ_ACCESS) && (!ctrl.mem_op || (eng_gnt && ctrl.mem_we));
    assign wb       = (state == SEQ_WB);
    assign step_end = apply || wb;
    assign op_done  = step_end && ctrl.last;
    assign busy     = (state != SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= SEQ_IDLE;
            opcode <= '0;
            is_y   <= 1'b0;
            step   <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (op_strobe) begin
                        state  <= SEQ_ACCESS;
                        opcode <= op_byte;
                        is_y   <= is_y_in;
                        step   <= '0;
                    end
                end
                SEQ_ACCESS: begin
                    if (ctrl.mem_op && !ctrl.mem_we && eng_gnt) state <= SEQ_WB;  // Data next cycle.
                end
                default: ;
            endcase
            if (step_end) begin
                if (ctrl.last) begin
                    state  <= SEQ_IDLE;
                    opcode <= '0;  // An unmatched opcode keeps the engine off the bus.
                    step   <= '0;
                end else begin
                    state <= SEQ_ACCESS;
                    step  <= step + 3'd1;
                end
            end
        end
    end

    // The requester must wait for the previous op to finish.
    assert property (@(posedge clk) disable iff (!rst_n) op_strobe |-> !busy)
        else $error("op_strobe while busy");

endmodule

// File: ixop_decoder.sv
// Index op decoder
`timescale 1ns/1ps

module ixop_decoder import ixop_pkg::*; (
    input  data_t opcode,
    input  logic  is_y,
    input  step_t step,
    output ctrl_t ctrl,
    output logic  known
);

    localparam data_t OP_POP  = 8'hE1;
    localparam data_t OP_EX   = 8'hE3;
    localparam data_t OP_PUSH = 8'hE5;
    localparam data_t OP_JP   = 8'hE9;
    localparam data_t OP_LDSP = 8'hF9;
    localparam data_t OP_CB   = 8'hCB;

    always_comb begin
        ctrl  = '0;
        known = 1'b1;
        case (opcode)
            // ****************************************
            // Stack transfers
            // ****************************************
            OP_POP: begin
                case (step)
                    3'd0: begin
                        ctrl.mem_op = 1'b1;
                        ctrl.wb_sel = WB_IDX_LO;
                        ctrl.inc_sp = 1'b1;
                    end
                    3'd1: begin
                        ctrl.mem_op = 1'b1;
                        ctrl.wb_sel = WB_IDX_HI;
                    end
                    3'd2: begin
                        ctrl.inc_sp = 1'b1;  // Steps past the high byte.
                        ctrl.last   = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_PUSH: begin
                case (step)
                    3'd0: ctrl.dec_sp = 1'b1;
                    3'd1: begin
                        ctrl.mem_op   = 1'b1;
                        ctrl.mem_we   = 1'b1;
                        ctrl.wdata_hi = 1'b1;
                        ctrl.dec_sp   = 1'b1;
                    end
                    3'd2: begin
                        ctrl.mem_op = 1'b1;
                        ctrl.mem_we = 1'b1;
                        ctrl.last   = 1'b1;
                    end
                    default: ;
                endcase
            end
            // Step 0 is an idle slot ahead of the two stack reads.
            OP_EX: begin
                case (step)
                    3'd1: begin
                        ctrl.mem_op = 1'b1;
                        ctrl.wb_sel = WB_DT;
                    end
                    3'd2: begin
                        ctrl.mem_op     = 1'b1;
                        ctrl.addr_plus1 = 1'b1;
                        ctrl.wb_sel     = WB_DTEX;
                    end
                    3'd3: begin
                        ctrl.mem_op = 1'b1;
                        ctrl.mem_we = 1'b1;
                    end
                    3'd4: begin
                        ctrl.mem_op      = 1'b1;
                        ctrl.mem_we      = 1'b1;
                        ctrl.addr_plus1  = 1'b1;
                        ctrl.wdata_hi    = 1'b1;
                        ctrl.idx_from_dt = 1'b1;  // Old stack word lands in the index.
                        ctrl.last        = 1'b1;
                    end
                    default: ;
                endcase
            end
            // ****************************************
            // Single step ops
            // ****************************************
            OP_JP: begin
                ctrl.write_pc = 1'b1;
                ctrl.last     = 1'b1;
            end
            OP_LDSP: begin
                ctrl.write_sp = 1'b1;
                ctrl.last     = 1'b1;
            end
            OP_CB: begin
                ctrl.set_cb = 1'b1;
                ctrl.last   = 1'b1;
            end
            default: begin
                known     = 1'b0;
                ctrl.last = 1'b1;
            end
        endcase
    end

    always_comb begin
        assert (!(ctrl.inc_sp && ctrl.dec_sp))
            else $error("SP moved both ways on %s op %h step %0d",
                        is_y ? "IY" : "IX", opcode, step);
    end

endmodule

// File: ixop_pkg.sv
// Index op types
`include "ixop_cfg.svh"

package ixop_pkg;

    typedef logic [`IXOP_ADDR_W-1:0] addr_t;
    typedef logic [`IXOP_DATA_W-1:0] data_t;
    typedef logic [2:0]              step_t;

    // Destination of a byte read from the stack.
    typedef enum logic [2:0] {
        WB_NONE,
        WB_IDX_LO,
        WB_IDX_HI,
        WB_DT,
        WB_DTEX
    } wb_sel_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ACCESS,
        SEQ_WB
    } seq_state_e;

    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic    mem_op;
        logic    mem_we;
        logic    addr_plus1;  // Address SP+1 instead of SP.
        logic    wdata_hi;    // Store the index high byte.
        wb_sel_e wb_sel;
        logic    inc_sp;
        logic    dec_sp;
        logic    write_pc;
        logic    write_sp;
        logic    idx_from_dt;
        logic    set_cb;
        logic    last;
    } ctrl_t;

    typedef struct packed {
        addr_t ix;
        addr_t iy;
        addr_t sp;
        addr_t pc;
    } regs_t;

endpackage

// File: ixop_cfg.svh
// Index op configuration
`ifndef IXOP_CFG_SVH
`define IXOP_CFG_SVH

// Address and data bus widths.
`define IXOP_ADDR_W 16
`define IXOP_DATA_W 8

// Stack RAM size in bytes.
`define IXOP_RAM_DEPTH 256

// Register contents after reset.
`define IXOP_SP_RESET 16'h00F0
`define IXOP_IX_RESET 16'h0000
`define IXOP_IY_RESET 16'h0000

`endif
